//--- Bender.yml
package:
  name: posit_mult

sources:
  - design/posit_pkg.sv
  - design/posit_lead_count.sv
  - design/posit_decoder.sv
  - design/posit_scale_mult.sv
  - design/posit_encoder.sv
  - design/posit_mult_top.sv
  - target: test
    files:
      - bench/posit_mult_checker.sv
      - bench/posit_mult_tb.sv

//--- bench/posit_mult_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Port-level assertions for posit_mult_top
module posit_mult_checker
	import posit_pkg::*;
(
	input wire               Clk,
	input wire               rst,
	input wire               start_i,
	input wire [POSIT_W-1:0] op_a_i,
	input wire [POSIT_W-1:0] op_b_i,
	input wire [POSIT_W-1:0] result_o,
	input wire               nar_o,
	input wire               zero_o,
	input wire               done_o
);

	int fail_cnt = 0;   // Assertion failures so far

	function automatic logic nar_case(input logic [POSIT_W-1:0] a,
		input logic [POSIT_W-1:0] b);
		return (a == POSIT_NAR) || (b == POSIT_NAR);
	endfunction

	// Zero result only when no NaR operand
	function automatic logic zero_case(input logic [POSIT_W-1:0] a,
		input logic [POSIT_W-1:0] b);
		return ((a == '0) || (b == '0)) && !nar_case(a, b);
	endfunction

	//////////////////////////////
	// Latency and reset
	//////////////////////////////
	a_start_to_done: assert property (@(posedge Clk) disable iff (rst)
		start_i |-> ##PIPE_DEPTH done_o)
		else begin
			$error("done_o missing three cycles after start_i");
			fail_cnt++;
		end

	a_done_from_start: assert property (@(posedge Clk) disable iff (rst)
		done_o |-> $past(start_i, PIPE_DEPTH))
		else begin
			$error("done_o without start_i three cycles before");
			fail_cnt++;
		end

	// Reset clears every output
	a_reset_values: assert property (@(posedge Clk)
		rst |=> (!done_o && result_o == '0 && !nar_o && !zero_o))
		else begin
			$error("outputs not cleared by reset");
			fail_cnt++;
		end

	a_hold: assert property (@(posedge Clk) disable iff (rst)
		!done_o |-> $stable(result_o) && $stable(nar_o) && $stable(zero_o))
		else begin
			$error("result changed between done pulses");
			fail_cnt++;
		end

	//////////////////////////////
	// Special operands
	//////////////////////////////
	a_nar_result: assert property (@(posedge Clk) disable iff (rst)
		done_o && nar_case($past(op_a_i, PIPE_DEPTH), $past(op_b_i, PIPE_DEPTH))
		|-> (result_o == POSIT_NAR) && nar_o)
		else begin
			$error("NaR operand did not give NaR");
			fail_cnt++;
		end

	a_nar_flag: assert property (@(posedge Clk) disable iff (rst)
		done_o
		|-> nar_o == nar_case($past(op_a_i, PIPE_DEPTH), $past(op_b_i, PIPE_DEPTH)))
		else begin
			$error("nar_o wrong");
			fail_cnt++;
		end

	a_zero_flag: assert property (@(posedge Clk) disable iff (rst)
		done_o
		|-> zero_o == zero_case($past(op_a_i, PIPE_DEPTH), $past(op_b_i, PIPE_DEPTH)))
		else begin
			$error("zero_o wrong");
			fail_cnt++;
		end

	// Zero operand without NaR clears the word
	a_zero_result: assert property (@(posedge Clk) disable iff (rst)
		done_o && zero_case($past(op_a_i, PIPE_DEPTH), $past(op_b_i, PIPE_DEPTH))
		|-> result_o == '0)
		else begin
			$error("zero operand gave a nonzero result");
			fail_cnt++;
		end

	// One times b gives b back
	a_identity: assert property (@(posedge Clk) disable iff (rst)
		done_o && $past(op_a_i, PIPE_DEPTH) == POSIT_ONE
		|-> result_o == $past(op_b_i, PIPE_DEPTH))
		else begin
			$error("one times b did not return b");
			fail_cnt++;
		end

endmodule

bind posit_mult_top posit_mult_checker u_checker (
	.Clk      (Clk),
	.rst      (rst),
	.start_i  (start_i),
	.op_a_i   (op_a_i),
	.op_b_i   (op_b_i),
	.result_o (result_o),
	.nar_o    (nar_o),
	.zero_o   (zero_o),
	.done_o   (done_o)
);

`default_nettype wire

//--- bench/posit_mult_tb.sv
`timescale 1ns/1ps
`default_nettype none

module posit_mult_tb
	import posit_pkg::*;
();

	localparam int N_ID   = 48;              // Identity pairs
	localparam int N_MIX  = 32;              // Random pairs with gaps
	localparam int N_SYM  = 40;              // Groups of three
	localparam int TAIL   = PIPE_DEPTH + 3;  // Drain plus spacing per phase
	localparam int STIM   = 3 + 10 + 6 + 8 + N_ID + 3 * N_MIX + 3 * N_SYM + 6 * TAIL;
	localparam int LIMIT  = 2 * STIM + PIPE_DEPTH + 20;

	// One issued operation
	typedef struct packed {
		logic [POSIT_W-1:0] a;
		logic [POSIT_W-1:0] b;
		logic [POSIT_W-1:0] exp;
		logic               has_exp;
		logic [1:0]         sym;      // 1 a*b, 2 b*a, 3 (-a)*b
	} job_t;

	logic               Clk;
	logic               rst;
	logic               start_i;
	logic [POSIT_W-1:0] op_a_i;
	logic [POSIT_W-1:0] op_b_i;
	logic [POSIT_W-1:0] result_o;
	logic               nar_o;
	logic               zero_o;
	logic               done_o;

	job_t               pending[$];   // Oldest issued operation at the front
	logic [POSIT_W-1:0] sym_ref;      // Result of a*b in current group
	integer             seed = 32'ha968_d261;
	int                 errors = 0;
	int                 cycles = 0;

	posit_mult_top uut (
		.Clk      (Clk),
		.rst      (rst),
		.start_i  (start_i),
		.op_a_i   (op_a_i),
		.op_b_i   (op_b_i),
		.result_o (result_o),
		.nar_o    (nar_o),
		.zero_o   (zero_o),
		.done_o   (done_o)
	);

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	function automatic job_t make_job(input logic [POSIT_W-1:0] a, input logic [POSIT_W-1:0] b,
		input logic [POSIT_W-1:0] exp, input logic has_exp, input logic [1:0] sym);
		job_t job;
		job.a       = a;
		job.b       = b;
		job.exp     = exp;
		job.has_exp = has_exp;
		job.sym     = sym;
		return job;
	endfunction

	task automatic drive_job(input job_t job);
		@(posedge Clk);
		start_i <= 1'b1;
		op_a_i  <= job.a;
		op_b_i  <= job.b;
		pending.push_back(job);
	endtask

	task automatic send_pair(input logic [POSIT_W-1:0] a, input logic [POSIT_W-1:0] b);
		drive_job(make_job(a, b, '0, 1'b0, 2'd0));
	endtask

	task automatic send_expect(input logic [POSIT_W-1:0] a, input logic [POSIT_W-1:0] b,
		input logic [POSIT_W-1:0] exp);
		drive_job(make_job(a, b, exp, 1'b1, 2'd0));
	endtask

	// Three back-to-back issues sharing one reference
	task automatic send_sym_group(input logic [POSIT_W-1:0] a, input logic [POSIT_W-1:0] b);
		drive_job(make_job(a, b, '0, 1'b0, 2'd1));
		drive_job(make_job(b, a, '0, 1'b0, 2'd2));
		drive_job(make_job(-a, b, '0, 1'b0, 2'd3));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge Clk);
			start_i <= 1'b0;
		end
	endtask

	// Wait until every issued operation has come back
	task automatic wait_drain();
		@(posedge Clk);
		start_i <= 1'b0;
		while (pending.size() != 0) begin
			@(posedge Clk);
		end
		idle_cycles(2);
	endtask

	// Mostly plain words with the odd NaR or zero
	function automatic logic [POSIT_W-1:0] random_operand();
		logic [POSIT_W-1:0] r;
		r = $random(seed);
		if (r[3:0] == 4'h0) begin
			r = POSIT_NAR;
		end else if (r[3:0] == 4'h1) begin
			r = '0;
		end
		return r;
	endfunction

	//////////////////////////////
	// Result checks
	//////////////////////////////
	task automatic report_mismatch(input string name, input logic [POSIT_W-1:0] got,
		input logic [POSIT_W-1:0] want, input job_t job);
		$display("[FAIL] %s: got %h, expected %h (op_a_i %h, op_b_i %h)",
			name, got, want, job.a, job.b);
		errors++;
	endtask

	task automatic check_result(input job_t job);
		logic any_nar;
		logic any_zero;
		any_nar  = (job.a == POSIT_NAR) || (job.b == POSIT_NAR);
		any_zero = ((job.a == '0) || (job.b == '0)) && !any_nar;
		if (any_nar) begin
			assert (result_o == POSIT_NAR)
				else report_mismatch("result_o", result_o, POSIT_NAR, job);
		end else if (any_zero) begin
			assert (result_o == '0)
				else report_mismatch("result_o", result_o, '0, job);
		end
		assert (nar_o == any_nar)
			else report_mismatch("nar_o", 32'(nar_o), 32'(any_nar), job);
		assert (zero_o == any_zero)
			else report_mismatch("zero_o", 32'(zero_o), 32'(any_zero), job);
		if (job.a == POSIT_ONE) begin
			assert (result_o == job.b)
				else report_mismatch("result_o", result_o, job.b, job);
		end
		if (job.has_exp) begin
			assert (result_o == job.exp)
				else report_mismatch("result_o", result_o, job.exp, job);
		end
		case (job.sym)
			2'd1: sym_ref = result_o;
			2'd2: begin
				assert (result_o == sym_ref)
					else report_mismatch("result_o", result_o, sym_ref, job);
			end
			2'd3: begin
				assert (result_o == -sym_ref)
					else report_mismatch("result_o", result_o, -sym_ref, job);
			end
			default: ;
		endcase
	endtask

	// Outputs are settled at the falling edge
	always @(negedge Clk) begin
		if (!rst && done_o) begin
			if (pending.size() == 0) begin
				$display("done_o pulsed with no operation in flight");
				errors++;
			end else begin
				check_result(pending.pop_front());
			end
		end
	end

	always @(posedge Clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles, %0d operations never finished",
				cycles, pending.size());
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		rst     = 1'b1;
		start_i = 1'b0;
		op_a_i  = '0;
		op_b_i  = '0;
		sym_ref = '0;
		repeat (3) @(posedge Clk);
		rst <= 1'b0;

		// NaR, zero and a few exact identities
		send_pair(POSIT_NAR, POSIT_ONE);
		send_pair(32'h1234_5678, POSIT_NAR);
		send_pair(POSIT_NAR, '0);
		send_pair('0, 32'hC000_0000);
		send_pair(32'h3A5A_5A5A, '0);
		send_pair(POSIT_NAR, POSIT_NAR);
		send_pair(POSIT_ONE, POSIT_ONE);
		send_pair(POSIT_ONE, 32'hC000_0000);   // One times minus one
		send_pair(POSIT_ONE, POSIT_MAXPOS);
		send_pair(POSIT_ONE, POSIT_MINPOS);
		wait_drain();

		// Gapped starts
		send_pair(POSIT_ONE, 32'h5000_0000);
		idle_cycles(1);
		send_pair(POSIT_ONE, 32'h3000_0000);
		idle_cycles(2);
		send_pair(POSIT_ONE, 32'hB7E1_5163);
		wait_drain();

		// Clamping at both ends of the range
		send_expect(POSIT_MAXPOS, POSIT_MAXPOS, POSIT_MAXPOS);
		send_expect(POSIT_MINPOS, POSIT_MINPOS, POSIT_MINPOS);
		send_expect(-POSIT_MAXPOS, POSIT_MAXPOS, -POSIT_MAXPOS);
		send_expect(POSIT_MAXPOS, -POSIT_MAXPOS, -POSIT_MAXPOS);
		send_expect(-POSIT_MINPOS, POSIT_MINPOS, -POSIT_MINPOS);
		send_expect(POSIT_MINPOS, -POSIT_MINPOS, -POSIT_MINPOS);
		send_expect(-POSIT_MAXPOS, -POSIT_MAXPOS, POSIT_MAXPOS);
		send_expect(POSIT_MAXPOS, POSIT_MINPOS, POSIT_ONE);   // 2^120 * 2^-120
		wait_drain();

		for (int i = 0; i < N_ID; i++) begin
			send_pair(POSIT_ONE, random_operand());
		end
		wait_drain();

		for (int i = 0; i < N_MIX; i++) begin
			send_pair(random_operand(), random_operand());
			idle_cycles(i % 3);
		end
		wait_drain();

		for (int i = 0; i < N_SYM; i++) begin
			send_sym_group(random_operand(), random_operand());
		end
		wait_drain();

		$display("Errors: testbench %0d, checker %0d", errors, uut.u_checker.fail_cnt);
		if (errors == 0 && uut.u_checker.fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/posit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// Posit word to sign, scale and significand
module posit_decoder
	import posit_pkg::*;
(
	input  wire [POSIT_W-1:0] posit_i,
	output posit_dec_t        dec_o
);

	logic [POSIT_W-1:0]          mag;       // Absolute value
	logic                        rc;        // First regime bit, 1 means k >= 0
	logic [POSIT_W-1:0]          run_bits;  // Regime as a run of ones
	logic [RUN_W-1:0]            run;       // Run length
	logic [SCALE_W-POSIT_ES-1:0] run_ext;
	logic [SCALE_W-POSIT_ES-1:0] k;         // Signed regime value
	logic [POSIT_W-2:0]          rest;      // Exponent then fraction, left aligned
	logic                        is_zero;
	logic                        is_nar;

	//////////////////////////////
	// Specials and magnitude
	//////////////////////////////
	assign is_zero = (posit_i == '0);
	assign is_nar  = (posit_i == POSIT_NAR);
	assign mag     = posit_i[POSIT_W-1] ? -posit_i : posit_i;  // 2's complement

	//////////////////////////////
	// Regime
	//////////////////////////////
	assign rc = mag[POSIT_W-2];

	// Zero runs flipped to ones, trailing 0 caps the count at 31
	assign run_bits = {(rc ? mag[POSIT_W-2:0] : ~mag[POSIT_W-2:0]), 1'b0};

	posit_lead_count u_lead (
		.bits_i  (run_bits),
		.count_o (run)
	);

	assign run_ext = {1'b0, run};
	assign k       = rc ? run_ext - 1'b1 : -run_ext;  // Ones: run-1, zeros: -run

	// Drop the first run bit here, then the rest of run plus terminator
	assign rest = {mag[POSIT_W-3:0], 1'b0} << run;

	//////////////////////////////
	// Pack
	//////////////////////////////
	always_comb begin
		dec_o.sign  = posit_i[POSIT_W-1];
		dec_o.zero  = is_zero;
		dec_o.nar   = is_nar;
		// 4*k + e as a plain concatenation
		dec_o.scale = {k, rest[POSIT_W-2 -: POSIT_ES]};
		dec_o.sig   = {1'b1, rest[POSIT_W-POSIT_ES-2:0]};  // Hidden one
	end

endmodule

`default_nettype wire

//--- design/posit_encoder.sv
`timescale 1ns/1ps
`default_nettype none

// Product back to a posit word, RNE and saturation
module posit_encoder
	import posit_pkg::*;
(
	input  wire posit_prod_t   prod_i,
	output logic [POSIT_W-1:0] posit_o,
	output logic               nar_o,
	output logic               zero_o
);

	logic signed [PSCALE_W-1:0]   scale;
	logic [PSCALE_W-POSIT_ES-1:0] k;          // floor(scale / 4)
	logic [POSIT_ES-1:0]          e;
	logic                         rv;         // Value of the regime run
	logic [PSCALE_W-POSIT_ES-1:0] len;        // Run length
	logic [ENC_W-1:0]             body_ext;   // Term bit, e, fraction
	logic [ENC_W-1:0]             run_mask;
	logic [ENC_W-1:0]             shifted;
	logic [POSIT_W-2:0]           mag;        // Magnitude below the sign
	logic                         guard;
	logic                         round;
	logic                         sticky;
	logic                         ulp;
	logic [POSIT_W-2:0]           mag_rnd;
	logic                         ovf;
	logic                         unf;
	logic [POSIT_W-2:0]           mag_sat;
	logic [POSIT_W-1:0]           word;

	//////////////////////////////
	// Regime and exponent
	//////////////////////////////
	assign scale = prod_i.scale;
	assign k     = scale[PSCALE_W-1:POSIT_ES];    // Arithmetic shift by es
	assign e     = scale[POSIT_ES-1:0];
	assign rv    = ~k[PSCALE_W-POSIT_ES-1];
	assign len   = rv ? k + 1'b1 : -k;             // k+1 ones or -k zeros

	//////////////////////////////
	// Place the run, shift the rest behind it
	//////////////////////////////
	// Term bit is the opposite of the run
	assign body_ext = {~rv, e, prod_i.mant[PROD_W-2:0], {(POSIT_W-1){1'b0}}};
	assign run_mask = {ENC_W{rv}} & ~({ENC_W{1'b1}} >> len);  // Top len bits
	assign shifted  = (body_ext >> len) | run_mask;

	assign mag    = shifted[ENC_W-1 -: POSIT_W-1];
	assign guard  = shifted[ENC_W-POSIT_W];
	assign round  = shifted[ENC_W-POSIT_W-1];
	assign sticky = |shifted[ENC_W-POSIT_W-2:0];

	//////////////////////////////
	// Round to nearest even
	//////////////////////////////
	// Tie goes to even LSB
	assign ulp     = guard & (round | sticky | mag[0]);
	assign mag_rnd = mag + ulp;   // All-ones mag never has guard set

	// Outside the range, clamp, never zero or NaR
	assign ovf = (scale > MAX_SCALE);
	assign unf = (scale < -MAX_SCALE);

	always_comb begin
		if (ovf) begin
			mag_sat = POSIT_MAXPOS[POSIT_W-2:0];
		end else if (unf) begin
			mag_sat = POSIT_MINPOS[POSIT_W-2:0];
		end else begin
			mag_sat = mag_rnd;
		end
	end

	// Negative results by 2's complement of the whole word
	assign word = prod_i.sign ? -{1'b0, mag_sat} : {1'b0, mag_sat};

	//////////////////////////////
	// Specials
	//////////////////////////////
	always_comb begin
		if (prod_i.nar) begin
			posit_o = POSIT_NAR;
		end else if (prod_i.zero) begin
			posit_o = '0;
		end else begin
			posit_o = word;
		end
	end

	assign nar_o  = prod_i.nar;
	assign zero_o = prod_i.zero;

endmodule

`default_nettype wire

//--- design/posit_lead_count.sv
`timescale 1ns/1ps
`default_nettype none

// Leading ones count, tree of pairwise halves
module posit_lead_count
	import posit_pkg::*;
(
	input  wire [POSIT_W-1:0] bits_i,
	output logic [RUN_W-1:0]  count_o
);

	logic [15:0] v1;        // Pair holds a zero
	logic [15:0] c1;        // Ones above that zero
	logic [7:0]  v2;
	logic [1:0]  c2 [8];
	logic [3:0]  v3;
	logic [2:0]  c3 [4];
	logic [1:0]  v4;
	logic [3:0]  c4 [2];

	genvar i;
	generate
		for (i = 0; i < 16; i++) begin : g_pair
			assign v1[i] = ~(bits_i[2*i+1] & bits_i[2*i]);
			assign c1[i] = bits_i[2*i+1];     // 1 only for pattern 10
		end
		// Upper half all ones, so count continues into lower half
		for (i = 0; i < 8; i++) begin : g_quad
			assign v2[i] = v1[2*i+1] | v1[2*i];
			assign c2[i] = v1[2*i+1] ? {1'b0, c1[2*i+1]} : {1'b1, c1[2*i]};
		end
		for (i = 0; i < 4; i++) begin : g_oct
			assign v3[i] = v2[2*i+1] | v2[2*i];
			assign c3[i] = v2[2*i+1] ? {1'b0, c2[2*i+1]} : {1'b1, c2[2*i]};
		end
		for (i = 0; i < 2; i++) begin : g_hex
			assign v4[i] = v3[2*i+1] | v3[2*i];
			assign c4[i] = v3[2*i+1] ? {1'b0, c3[2*i+1]} : {1'b1, c3[2*i]};
		end
	endgenerate

	// All ones saturates at 31
	assign count_o = v4[1] ? {1'b0, c4[1]} :
	                 v4[0] ? {1'b1, c4[0]} : {RUN_W{1'b1}};

endmodule

`default_nettype wire

//--- design/posit_mult_top.sv
`timescale 1ns/1ps
`default_nettype none

// Three stage posit multiplier: decode, multiply, encode
module posit_mult_top
	import posit_pkg::*;
(
	input  wire                Clk,
	input  wire                rst,
	input  wire                start_i,   // One cycle, operands valid
	input  wire  [POSIT_W-1:0] op_a_i,
	input  wire  [POSIT_W-1:0] op_b_i,
	output logic [POSIT_W-1:0] result_o,
	output logic               nar_o,
	output logic               zero_o,
	output logic               done_o     // start_i delayed by PIPE_DEPTH
);

	posit_dec_t         dec_a;
	posit_dec_t         dec_b;
	posit_dec_t         dec_a_q;   // Stage 1 payload
	posit_dec_t         dec_b_q;
	logic               vld1_q;
	posit_prod_t        prod;
	posit_prod_t        prod_q;    // Stage 2 payload
	logic               vld2_q;
	logic [POSIT_W-1:0] enc_posit;
	logic               enc_nar;
	logic               enc_zero;

	//////////////////////////////
	// Stage 1, decode
	//////////////////////////////
	posit_decoder u_dec_a (.posit_i(op_a_i), .dec_o(dec_a));
	posit_decoder u_dec_b (.posit_i(op_b_i), .dec_o(dec_b));

	// Stage 2 logic
	posit_scale_mult u_mult (
		.dec_a_i (dec_a_q),
		.dec_b_i (dec_b_q),
		.prod_o  (prod)
	);

	// Stage 3 logic
	posit_encoder u_enc (
		.prod_i  (prod_q),
		.posit_o (enc_posit),
		.nar_o   (enc_nar),
		.zero_o  (enc_zero)
	);

	//////////////////////////////
	// Valid chain
	//////////////////////////////
	always_ff @(posedge Clk) begin
		if (rst) begin
			vld1_q <= 1'b0;
			vld2_q <= 1'b0;
		end else begin
			vld1_q <= start_i;
			vld2_q <= vld1_q;
		end
	end

	// Payload loads only with its valid
	always_ff @(posedge Clk) begin
		if (start_i) begin
			dec_a_q <= dec_a;
			dec_b_q <= dec_b;
		end
		if (vld1_q) begin
			prod_q <= prod;
		end
	end

	// Outputs hold until the next done
	always_ff @(posedge Clk) begin
		if (rst) begin
			result_o <= '0;
			nar_o    <= 1'b0;
			zero_o   <= 1'b0;
			done_o   <= 1'b0;
		end else begin
			done_o <= vld2_q;
			if (vld2_q) begin
				result_o <= enc_posit;
				nar_o    <= enc_nar;
				zero_o   <= enc_zero;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/posit_pkg.sv
`default_nettype none

package posit_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////
	localparam int POSIT_W    = 32;                  // Posit word
	localparam int POSIT_ES   = 2;                   // Exponent field
	localparam int RUN_W      = 5;                   // Regime run count, log2 of POSIT_W
	localparam int SCALE_W    = 8;                   // 4*k + e of one operand
	localparam int PSCALE_W   = SCALE_W + 1;         // Sum of two scales plus carry
	localparam int SIG_W      = POSIT_W - POSIT_ES;  // Hidden bit plus fraction
	localparam int PROD_W     = 2 * SIG_W;           // Full significand product
	localparam int PIPE_DEPTH = 3;                   // start_i to done_o

	// Largest scale magnitude, maxpos is 2^120
	localparam int MAX_SCALE  = (POSIT_W - 2) << POSIT_ES;

	// Encoder vector: term bit, exponent, fraction, then room for the run
	localparam int ENC_BODY_W = 1 + POSIT_ES + PROD_W - 1;
	localparam int ENC_W      = ENC_BODY_W + POSIT_W - 1;

	//////////////////////////////
	// Special encodings
	//////////////////////////////
	localparam logic [POSIT_W-1:0] POSIT_NAR    = {1'b1, {(POSIT_W-1){1'b0}}};
	localparam logic [POSIT_W-1:0] POSIT_MAXPOS = {1'b0, {(POSIT_W-1){1'b1}}};
	localparam logic [POSIT_W-1:0] POSIT_MINPOS = {{(POSIT_W-1){1'b0}}, 1'b1};
	localparam logic [POSIT_W-1:0] POSIT_ONE    = {2'b01, {(POSIT_W-2){1'b0}}};

	//////////////////////////////
	// Decoded operand, 41 bits
	//////////////////////////////
	typedef struct packed {
		logic                      sign;   // Sign of the original word
		logic                      zero;
		logic                      nar;
		logic signed [SCALE_W-1:0] scale;  // Regime and exponent combined
		logic [SIG_W-1:0]          sig;    // Hidden one at the top
	} posit_dec_t;

	// Normalized product, 72 bits
	typedef struct packed {
		logic                       sign;
		logic                       zero;  // Only when no NaR
		logic                       nar;
		logic signed [PSCALE_W-1:0] scale;
		logic [PROD_W-1:0]          mant;  // Hidden one in the top bit
	} posit_prod_t;

endpackage

`default_nettype wire

//--- design/posit_scale_mult.sv
`timescale 1ns/1ps
`default_nettype none

// Scale add, significand multiply, one-bit normalize
module posit_scale_mult
	import posit_pkg::*;
(
	input  wire posit_dec_t dec_a_i,
	input  wire posit_dec_t dec_b_i,
	output posit_prod_t     prod_o
);

	logic [PROD_W-1:0]   raw;       // Significand product
	logic                top;       // Product in [2,4)
	logic [PSCALE_W-1:0] scale_a;
	logic [PSCALE_W-1:0] scale_b;
	logic [PSCALE_W-1:0] sum;
	logic                any_nar;

	// Both sigs in [1,2), product in [1,4)
	assign raw = dec_a_i.sig * dec_b_i.sig;
	assign top = raw[PROD_W-1];

	// Sign extend before adding
	assign scale_a = {dec_a_i.scale[SCALE_W-1], dec_a_i.scale};
	assign scale_b = {dec_b_i.scale[SCALE_W-1], dec_b_i.scale};
	assign sum     = scale_a + scale_b;

	assign any_nar = dec_a_i.nar | dec_b_i.nar;

	always_comb begin
		prod_o.sign = dec_a_i.sign ^ dec_b_i.sign;
		prod_o.nar  = any_nar;
		// NaR wins over zero
		prod_o.zero = (dec_a_i.zero | dec_b_i.zero) & ~any_nar;

		// Top set: bump scale. Else shift up so the hidden one sits on top
		if (top) begin
			prod_o.scale = sum + 1'b1;
			prod_o.mant  = raw;
		end else begin
			prod_o.scale = sum;
			prod_o.mant  = raw << 1;
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
design/posit_pkg.sv
design/posit_lead_count.sv
design/posit_decoder.sv
design/posit_scale_mult.sv
design/posit_encoder.sv
design/posit_mult_top.sv
bench/posit_mult_checker.sv
bench/posit_mult_tb.sv
